// ==== files.f ====
+incdir+include
rtl/hdmi_cfg_pkg.sv
rtl/i2c_req_if.sv
rtl/mode_ctl.sv
rtl/i2c_write_master.sv
rtl/chip_init_seq.sv
rtl/hdmi_cfg_top.sv
testbench/hdmi_cfg_chk.sv
testbench/hdmi_cfg_tb.sv

// ==== include/hdmi_cfg_settings.svh ====
// shared counts, i2c device addresses and bus timing, included by rtl and testbench
`ifndef HDMI_CFG_SETTINGS_SVH
`define HDMI_CFG_SETTINGS_SVH

// cycles from pll lock until the chip reset may release
`define HDMI_CFG_RSTN_TIME 16'd10000

// register writes per init table
`define HDMI_CFG_TABLE_LEN 4

// 7-bit device addresses, receive chip first
`define HDMI_CFG_RX_DEV 7'h2B
`define HDMI_CFG_TX_DEV 7'h59

// cycles per quarter scl period
// four quarters make one bit, 152 quarters one frame
`define HDMI_CFG_I2C_QUARTER 25

`endif

// ==== rtl/chip_init_seq.sv ====
// walks the rx then tx init tables, one i2c write request per entry
`timescale 1ns/1ns
`include "hdmi_cfg_settings.svh"

module chip_init_seq (
    input  logic   ms72xx_cfg_clk,
    input  logic   rst,
    input  logic   chip_rstn,              // low holds the sequencer idle
    i2c_req_if.seq rx,
    i2c_req_if.seq tx,
    output logic   init_done,
    output logic   cfg_err
);
    import hdmi_cfg_pkg::*;

    localparam int IDX_W = $clog2(`HDMI_CFG_TABLE_LEN);

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_DONE} seq_state_t;

    seq_state_t       state;
    logic [IDX_W-1:0] idx;                 // table entry
    logic             side;                // 0 rx table, 1 tx table
    logic             rx_start_q;
    logic             tx_start_q;
    logic             done_q;
    logic             err_q;               // sticky nack
    logic             cur_done;
    logic             cur_nack;
    logic             last_idx;

    assign cur_done = side ? tx.done : rx.done;
    assign cur_nack = side ? tx.nack : rx.nack;
    assign last_idx = (idx == IDX_W'(`HDMI_CFG_TABLE_LEN - 1));

    always_ff @(posedge ms72xx_cfg_clk) begin
        if (rst || !chip_rstn) begin       // restarts from entry 0 on next release
            state      <= S_IDLE;
            idx        <= '0;
            side       <= 1'b0;
            rx_start_q <= 1'b0;
            tx_start_q <= 1'b0;
            done_q     <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            case (state)
                S_IDLE: state <= S_ISSUE;  // one cycle after release
                S_ISSUE: begin
                    rx_start_q <= !side;
                    tx_start_q <= side;
                    state      <= S_WAIT;
                end
                S_WAIT: begin
                    rx_start_q <= 1'b0;    // single-cycle start
                    tx_start_q <= 1'b0;
                    if (cur_done) begin
                        if (cur_nack)
                            err_q <= 1'b1;
                        if (!last_idx) begin
                            idx   <= idx + 1'b1;
                            state <= S_ISSUE;
                        end else if (!side) begin
                            side  <= 1'b1; // rx table done, move to tx
                            idx   <= '0;
                            state <= S_ISSUE;
                        end else begin
                            done_q <= 1'b1;
                            state  <= S_DONE;
                        end
                    end
                end
                default: state <= S_DONE;  // stays until chip_rstn drops
            endcase
        end
    end

    assign rx.start = rx_start_q;
    assign tx.start = tx_start_q;
    assign rx.wr    = rx_init_table[idx];  // stable while waiting on done
    assign tx.wr    = tx_init_table[idx];

    // both flags drop in the same cycle as chip_rstn
    assign init_done = done_q && chip_rstn;
    assign cfg_err   = err_q && chip_rstn;

endmodule

// ==== rtl/hdmi_cfg_pkg.sv ====
// common types and the fixed register tables for the hdmi chip configuration
`include "hdmi_cfg_settings.svh"

package hdmi_cfg_pkg;

    typedef enum logic [1:0] {
        MODE_HDMI = 2'd0,                  // hdmi source, chips enabled
        MODE_ETH  = 2'd1,                  // ethernet source
        MODE_AD   = 2'd2                   // ad source
    } mode_t;

    typedef struct packed {
        logic [15:0] reg_addr;             // sent high byte first
        logic [7:0]  data;
    } reg_write_t;

    // receive chip init sequence
    localparam reg_write_t rx_init_table [`HDMI_CFG_TABLE_LEN] = '{
        '{16'h1281, 8'h04}, '{16'h0100, 8'h16}, '{16'h1D02, 8'h3A}, '{16'h2070, 8'hC5}
    };

    // transmit chip init, written after the receive table
    localparam reg_write_t tx_init_table [`HDMI_CFG_TABLE_LEN] = '{
        '{16'h0A30, 8'h81}, '{16'h1041, 8'h27}, '{16'h3A0F, 8'h9E}, '{16'h0B62, 8'h5D}
    };

endpackage

// ==== rtl/hdmi_cfg_top.sv ====
// hdmi side top, mode control plus rx/tx chip init over two i2c buses
`timescale 1ns/1ns
`include "hdmi_cfg_settings.svh"

module hdmi_cfg_top (
    input  logic ms72xx_cfg_clk,
    input  logic rst,
    input  logic pll_lock,
    input  logic btn_hdmi,
    input  logic btn_ethernet,
    input  logic btn_ad,
    input  logic iic_sda_in,
    input  logic iic_tx_sda_in,
    output logic hdmi_valid,
    output logic ethernet_valid,
    output logic ad_valid,
    output logic source_rst,
    output logic chip_rstn,
    output logic iic_scl,
    output logic iic_sda_oe,
    output logic iic_tx_scl,
    output logic iic_tx_sda_oe,
    output logic init_done,
    output logic cfg_err
);

    i2c_req_if rx_req ();                  // sequencer to receive chip engine
    i2c_req_if tx_req ();                  // sequencer to transmit chip engine

    mode_ctl u_mode_ctl (
        .ms72xx_cfg_clk (ms72xx_cfg_clk),
        .rst            (rst),
        .pll_lock       (pll_lock),
        .btn_hdmi       (btn_hdmi),
        .btn_ethernet   (btn_ethernet),
        .btn_ad         (btn_ad),
        .hdmi_valid     (hdmi_valid),
        .ethernet_valid (ethernet_valid),
        .ad_valid       (ad_valid),
        .source_rst     (source_rst),
        .chip_rstn      (chip_rstn)
    );

    chip_init_seq u_seq (
        .ms72xx_cfg_clk (ms72xx_cfg_clk),
        .rst            (rst),
        .chip_rstn      (chip_rstn),       // run enable for the whole init
        .rx             (rx_req),
        .tx             (tx_req),
        .init_done      (init_done),
        .cfg_err        (cfg_err)
    );

    i2c_write_master #(.dev_addr(`HDMI_CFG_RX_DEV)) u_rx_i2c (
        .ms72xx_cfg_clk (ms72xx_cfg_clk),
        .rst            (rst),
        .run            (chip_rstn),
        .sda_in         (iic_sda_in),
        .req            (rx_req),
        .scl            (iic_scl),
        .sda_oe         (iic_sda_oe)
    );

    i2c_write_master #(.dev_addr(`HDMI_CFG_TX_DEV)) u_tx_i2c (
        .ms72xx_cfg_clk (ms72xx_cfg_clk),
        .rst            (rst),
        .run            (chip_rstn),
        .sda_in         (iic_tx_sda_in),
        .req            (tx_req),
        .scl            (iic_tx_scl),
        .sda_oe         (iic_tx_sda_oe)
    );

endmodule

// ==== rtl/i2c_req_if.sv ====
// one register write request between the init sequencer and an i2c write engine
`timescale 1ns/1ns

interface i2c_req_if;
    import hdmi_cfg_pkg::*;

    logic       start;                     // one-cycle request pulse
    reg_write_t wr;                        // held by requester until done
    logic       done;                      // one-cycle pulse at frame end
    logic       nack;                      // valid with done

    modport seq (
        output start,
        output wr,
        input  done,
        input  nack
    );

    modport eng (
        input  start,
        input  wr,
        output done,
        output nack
    );

endinterface

// ==== rtl/i2c_write_master.sv ====
// i2c engine that sends one device/addr-hi/addr-lo/data write frame per request
`timescale 1ns/1ns
`include "hdmi_cfg_settings.svh"

module i2c_write_master #(
    parameter logic [6:0] dev_addr = 7'h00
) (
    input  logic   ms72xx_cfg_clk,
    input  logic   rst,
    input  logic   run,                    // low forces idle, lines released
    input  logic   sda_in,
    i2c_req_if.eng req,
    output logic   scl,
    output logic   sda_oe                  // 1 pulls sda low
);
    localparam int DIV_W = $clog2(`HDMI_CFG_I2C_QUARTER);

    typedef enum logic [1:0] {E_IDLE, E_START, E_BITS, E_STOP} eng_state_t;

    eng_state_t       state;
    logic [DIV_W-1:0] div_cnt;             // quarter period divider
    logic [1:0]       phase;               // quarter within bit or condition
    logic [3:0]       bit_cnt;             // 0..7 data, 8 ack
    logic [1:0]       byte_cnt;
    logic [31:0]      shift;               // frame bits, msb first
    logic             nack_q;
    logic             done_q;
    logic             qtick;
    logic             load;
    logic             ack_bit;

    assign qtick   = (div_cnt == DIV_W'(`HDMI_CFG_I2C_QUARTER - 1));
    assign load    = run && (state == E_IDLE) && req.start;  // busy start ignored
    assign ack_bit = (bit_cnt == 4'd8);

    always_ff @(posedge ms72xx_cfg_clk) begin
        if (rst || !run) begin
            state    <= E_IDLE;
            div_cnt  <= '0;
            phase    <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            nack_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state == E_IDLE) begin
                div_cnt <= '0;
                phase   <= '0;
                if (load) begin
                    state  <= E_START;
                    nack_q <= 1'b0;            // fresh result per frame
                end
            end else begin
                div_cnt <= qtick ? '0 : div_cnt + 1'b1;
                if (qtick) begin
                    phase <= phase + 2'd1;
                    // sample ack mid scl high
                    if (state == E_BITS && ack_bit && phase == 2'd1 && sda_in)
                        nack_q <= 1'b1;
                    if (phase == 2'd3) begin
                        case (state)
                            E_START: begin
                                state    <= E_BITS;
                                bit_cnt  <= '0;
                                byte_cnt <= '0;
                            end
                            E_BITS: begin
                                if (ack_bit) begin
                                    bit_cnt <= '0;
                                    if (byte_cnt == 2'd3)
                                        state <= E_STOP;
                                    else
                                        byte_cnt <= byte_cnt + 2'd1;
                                end else begin
                                    bit_cnt <= bit_cnt + 4'd1;
                                end
                            end
                            E_STOP: begin
                                state  <= E_IDLE;
                                done_q <= 1'b1;    // frame complete
                            end
                            default: state <= E_IDLE;
                        endcase
                    end
                end
            end
        end
    end

    // frame payload, shifts after each data bit, not on ack
    always_ff @(posedge ms72xx_cfg_clk) begin
        if (load)
            shift <= {dev_addr, 1'b0, req.wr.reg_addr, req.wr.data};
        else if (state == E_BITS && qtick && phase == 2'd3 && !ack_bit)
            shift <= {shift[30:0], 1'b0};
    end

    // scl low in quarters 0 and 3 of a bit, sda moves only there
    always_comb begin
        case (state)
            E_START: begin
                scl    = (phase != 2'd3);
                sda_oe = (phase != 2'd0);      // sda falls while scl high
            end
            E_BITS: begin
                scl    = (phase == 2'd1) || (phase == 2'd2);
                sda_oe = !ack_bit && !shift[31];   // released during ack
            end
            E_STOP: begin
                scl    = (phase != 2'd0);
                sda_oe = (phase != 2'd3);      // sda rises while scl high
            end
            default: begin
                scl    = 1'b1;
                sda_oe = 1'b0;
            end
        endcase
    end

    assign req.done = done_q;
    assign req.nack = nack_q;

endmodule

// ==== rtl/mode_ctl.sv ====
// source mode register from three buttons, source reset pulse and delayed chip reset
`timescale 1ns/1ns
`include "hdmi_cfg_settings.svh"

module mode_ctl (
    input  logic ms72xx_cfg_clk,
    input  logic rst,
    input  logic pll_lock,
    input  logic btn_hdmi,
    input  logic btn_ethernet,
    input  logic btn_ad,
    output logic hdmi_valid,
    output logic ethernet_valid,
    output logic ad_valid,
    output logic source_rst,
    output logic chip_rstn
);
    import hdmi_cfg_pkg::*;

    mode_t       mode;                     // current source
    mode_t       mode_nxt;
    logic [2:0]  btn_s1;                   // {ad, eth, hdmi}, first sync stage
    logic [2:0]  btn_s2;                   // second sync stage
    logic [2:0]  btn_d;                    // delayed copy for edge detect
    logic [2:0]  btn_rise;
    logic [15:0] rstn_cnt;                 // power-up delay counter
    logic        cnt_full;

    // two-flop sync then edge detect
    always_ff @(posedge ms72xx_cfg_clk) begin
        if (rst) begin
            btn_s1 <= '0;
            btn_s2 <= '0;
            btn_d  <= '0;
        end else begin
            btn_s1 <= {btn_ad, btn_ethernet, btn_hdmi};
            btn_s2 <= btn_s1;
            btn_d  <= btn_s2;
        end
    end

    assign btn_rise = btn_s2 & ~btn_d;

    // hdmi wins over ethernet, ethernet over ad
    always_comb begin
        mode_nxt = mode;
        if (btn_rise[0])
            mode_nxt = MODE_HDMI;
        else if (btn_rise[1])
            mode_nxt = MODE_ETH;
        else if (btn_rise[2])
            mode_nxt = MODE_AD;
    end

    always_ff @(posedge ms72xx_cfg_clk) begin
        if (rst) begin
            mode       <= MODE_HDMI;
            source_rst <= 1'b0;
        end else begin
            mode       <= mode_nxt;
            source_rst <= (mode_nxt != mode);  // same-mode press gives no pulse
        end
    end

    assign hdmi_valid     = (mode == MODE_HDMI);
    assign ethernet_valid = (mode == MODE_ETH);
    assign ad_valid       = (mode == MODE_AD);

    // counts from pll lock, saturates at full
    always_ff @(posedge ms72xx_cfg_clk) begin
        if (rst || !pll_lock)
            rstn_cnt <= '0;
        else if (!cnt_full)
            rstn_cnt <= rstn_cnt + 16'd1;
    end

    assign cnt_full = (rstn_cnt == `HDMI_CFG_RSTN_TIME);

    // follows mode_nxt so it drops in the same cycle hdmi_valid does
    always_ff @(posedge ms72xx_cfg_clk) begin
        if (rst)
            chip_rstn <= 1'b0;
        else
            chip_rstn <= cnt_full && (mode_nxt == MODE_HDMI);
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compiles the hdmi_cfg testbench with verilator, runs it and checks the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module hdmi_cfg_tb -f files.f -o hdmi_cfg_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/hdmi_cfg_sim +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

// ==== testbench/hdmi_cfg_chk.sv ====
// concurrent assertions on the hdmi_cfg_top outputs, bound into every hdmi_cfg_top
`timescale 1ns/1ns

module hdmi_cfg_chk (
    input logic ms72xx_cfg_clk,
    input logic rst,
    input logic hdmi_valid,
    input logic ethernet_valid,
    input logic ad_valid,
    input logic source_rst,
    input logic chip_rstn,
    input logic init_done,
    input logic iic_scl,
    input logic iic_tx_scl
);
    int fails;                             // read by the testbench verdict

    task automatic note_failure(input string what);
        fails = fails + 1;
        $error("%s", what);
    endtask

    assert property (@(posedge ms72xx_cfg_clk) disable iff (rst)
        $onehot({hdmi_valid, ethernet_valid, ad_valid}))
        else note_failure("source valids not one-hot");

    assert property (@(posedge ms72xx_cfg_clk) disable iff (rst)
        source_rst |=> !source_rst)
        else note_failure("source_rst high for two cycles");

    // chip reset only released in hdmi mode
    assert property (@(posedge ms72xx_cfg_clk) disable iff (rst)
        chip_rstn |-> hdmi_valid)
        else note_failure("chip_rstn high outside hdmi mode");

    assert property (@(posedge ms72xx_cfg_clk) disable iff (rst)
        init_done |-> chip_rstn)
        else note_failure("init_done high while chips in reset");

    assert property (@(posedge ms72xx_cfg_clk) disable iff (rst)
        iic_scl || iic_tx_scl)
        else note_failure("both scl lines low together");

endmodule

bind hdmi_cfg_top hdmi_cfg_chk u_chk (.*);

// ==== testbench/hdmi_cfg_tb.sv ====
// testbench for hdmi_cfg_top, run as top with uut, covers reset delay, init frames, buttons, nack
`timescale 1ns/1ns
`include "hdmi_cfg_settings.svh"

module i2c_slave_model (
    input  logic        scl,
    input  logic        sda_oe,            // master pulls sda low
    input  logic        nack_all,          // answer every byte with nack
    output logic        sda_in,
    output logic [31:0] frame,             // last complete frame
    output int          frame_cnt
);
    int          bit_cnt;                  // scl rises since start condition
    logic [31:0] shift;
    logic        ack_pull;

    initial begin
        ack_pull = 1'b0;
        bit_cnt  = 36;                     // idle until first start
    end

    assign sda_in = !sda_oe && !ack_pull;  // open drain with pull-up

    always @(posedge sda_oe) begin
        if (scl === 1'b1)
            bit_cnt = 0;                   // start, sda falls while scl high
    end

    always @(posedge scl) begin
        if (bit_cnt < 36) begin
            if (bit_cnt % 9 != 8)
                shift = {shift[30:0], sda_in};  // ack bits not stored
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 36) begin
                frame     = shift;
                frame_cnt = frame_cnt + 1;
            end
        end
    end

    // hold sda low through the ninth clock of each byte
    always @(negedge scl)
        ack_pull = (bit_cnt < 36) && (bit_cnt % 9 == 8) && !nack_all;
endmodule

module hdmi_cfg_tb;
    import hdmi_cfg_pkg::*;

    localparam int table_len = `HDMI_CFG_TABLE_LEN;
    localparam int rows      = 5;
    localparam longint watchdog_ns = (longint'(`HDMI_CFG_RSTN_TIME)
        + 3 * 2 * table_len * 152 * `HDMI_CFG_I2C_QUARTER) * 10 * 2;

    typedef struct packed {
        logic [2:0] btn;                   // {ad, eth, hdmi}
        mode_t      mode;                  // expected mode afterwards
        logic [1:0] pulses;                // expected source_rst pulses
    } btn_row_t;

    localparam btn_row_t btn_table [rows] = '{
        '{3'b010, MODE_ETH,  2'd1},        // leave hdmi
        '{3'b010, MODE_ETH,  2'd0},        // current mode again
        '{3'b100, MODE_AD,   2'd1},
        '{3'b110, MODE_ETH,  2'd1},        // eth beats ad
        '{3'b111, MODE_HDMI, 2'd1}         // hdmi beats both, init reruns
    };

    logic        ms72xx_cfg_clk;
    logic        rst;
    logic        pll_lock;
    logic        btn_hdmi, btn_ethernet, btn_ad;
    logic        iic_sda_in, iic_tx_sda_in;         // driven by slave models
    logic        hdmi_valid, ethernet_valid, ad_valid;
    logic        source_rst, chip_rstn, init_done, cfg_err;
    logic        iic_scl, iic_sda_oe, iic_tx_scl, iic_tx_sda_oe;
    logic        tx_nack;                  // tx slave nacks every byte
    logic [31:0] rx_frame, tx_frame;
    int          rx_cnt, tx_cnt;
    logic [31:0] rx_frames [$];
    logic [31:0] tx_frames [$];
    int          pulses;                   // source_rst pulses this row
    int          checks;
    int          errors;

    hdmi_cfg_top uut (.*);

    i2c_slave_model rx_slave (
        .scl       (iic_scl),
        .sda_oe    (iic_sda_oe),
        .nack_all  (1'b0),
        .sda_in    (iic_sda_in),
        .frame     (rx_frame),
        .frame_cnt (rx_cnt)
    );

    i2c_slave_model tx_slave (
        .scl       (iic_tx_scl),
        .sda_oe    (iic_tx_sda_oe),
        .nack_all  (tx_nack),
        .sda_in    (iic_tx_sda_in),
        .frame     (tx_frame),
        .frame_cnt (tx_cnt)
    );

    always #5 ms72xx_cfg_clk = !ms72xx_cfg_clk;

    always @(posedge ms72xx_cfg_clk)
        if (source_rst === 1'b1)
            pulses <= pulses + 1;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // frame word settled well before the next falling clock edge
    always @(rx_cnt) begin
        @(negedge ms72xx_cfg_clk);
        rx_frames.push_back(rx_frame);
    end

    always @(tx_cnt) begin
        @(negedge ms72xx_cfg_clk);
        tx_frames.push_back(tx_frame);
        check(rx_frames.size(), table_len, "rx table finished before tx frame");
    end

    // device byte with write bit, then address high, address low, data
    function automatic logic [31:0] expected_frame(input logic [6:0] dev, input reg_write_t wr);
        return {dev, 1'b0, wr.reg_addr, wr.data};
    endfunction

    task automatic check_init_frames(input logic exp_err);
        wait (init_done === 1'b1);
        @(negedge ms72xx_cfg_clk);             // settled values
        check(rx_frames.size(), table_len, "rx frame count");
        check(tx_frames.size(), table_len, "tx frame count");
        for (int i = 0; i < table_len; i++) begin
            if (i < rx_frames.size())
                check(rx_frames[i], expected_frame(`HDMI_CFG_RX_DEV, rx_init_table[i]),
                    $sformatf("rx frame %0d", i));
            if (i < tx_frames.size())
                check(tx_frames[i], expected_frame(`HDMI_CFG_TX_DEV, tx_init_table[i]),
                    $sformatf("tx frame %0d", i));
        end
        check(cfg_err, exp_err, "cfg_err at init_done");
    endtask

    task automatic press_buttons(input logic [2:0] btn);
        @(posedge ms72xx_cfg_clk);
        #1 {btn_ad, btn_ethernet, btn_hdmi} = btn;
        repeat (6) @(posedge ms72xx_cfg_clk);
        #1 {btn_ad, btn_ethernet, btn_hdmi} = 3'b000;
    endtask

    initial begin
        #(watchdog_ns);
        $display("simulation timed out at %0t ns waiting on the dut", $time);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int    gap;
        mode_t m;
        void'($urandom(1));                // fixed seed for press gaps
        ms72xx_cfg_clk = 1'b0;
        rst            = 1'b1;
        pll_lock       = 1'b0;
        tx_nack        = 1'b0;
        {btn_ad, btn_ethernet, btn_hdmi} = 3'b000;
        repeat (16) @(posedge ms72xx_cfg_clk);
        #1 rst = 1'b0;
        rx_frames.delete();
        tx_frames.delete();
        check({hdmi_valid, ethernet_valid, ad_valid}, 3'b100, "valids after reset");
        check({source_rst, chip_rstn, init_done, cfg_err}, 4'b0000, "controls after reset");
        check({iic_scl, iic_tx_scl, iic_sda_oe, iic_tx_sda_oe}, 4'b1100, "i2c idle after reset");
        @(posedge ms72xx_cfg_clk);
        #1 pll_lock = 1'b1;
        repeat (`HDMI_CFG_RSTN_TIME - 1) @(posedge ms72xx_cfg_clk);
        #1 check(chip_rstn, 1'b0, "chip_rstn before delay ends");
        repeat (3) @(posedge ms72xx_cfg_clk);
        #1 check(chip_rstn, 1'b1, "chip_rstn after delay");
        check_init_frames(1'b0);
        rx_frames.delete();
        tx_frames.delete();
        for (int r = 0; r < rows; r++) begin
            pulses = 0;
            press_buttons(btn_table[r].btn);
            gap = 4 + int'($urandom % 16);
            repeat (gap) @(posedge ms72xx_cfg_clk);
            #1 m = btn_table[r].mode;
            check({ad_valid, ethernet_valid, hdmi_valid},
                {m == MODE_AD, m == MODE_ETH, m == MODE_HDMI}, $sformatf("row %0d mode", r));
            check(pulses, btn_table[r].pulses, $sformatf("row %0d source_rst pulses", r));
            check(chip_rstn, m == MODE_HDMI, $sformatf("row %0d chip_rstn", r));
            if (m != MODE_HDMI)
                check({init_done, cfg_err, iic_scl, iic_tx_scl, iic_sda_oe, iic_tx_sda_oe},
                    6'b001100, $sformatf("row %0d outputs idle outside hdmi", r));
        end
        check_init_frames(1'b0);               // re-entry gives the same frames
        tx_nack = 1'b1;
        press_buttons(3'b010);                 // leave hdmi so init reruns
        rx_frames.delete();
        tx_frames.delete();
        press_buttons(3'b001);
        check_init_frames(1'b1);
        press_buttons(3'b010);                 // leave with cfg_err set
        check({chip_rstn, init_done, cfg_err}, 3'b000, "flags after leaving hdmi");
        press_buttons(3'b001);                 // rerun, then leave inside the start condition
        wait (iic_sda_oe === 1'b1);
        press_buttons(3'b010);
        check({iic_scl, iic_tx_scl, iic_sda_oe, iic_tx_sda_oe}, 4'b1100,
            "buses idle after leaving mid-frame");
        $display("checks %0d, errors %0d, assertion failures %0d",
            checks, errors, uut.u_chk.fails);
        if (errors == 0 && uut.u_chk.fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
